/* rtl/ids_pkg.sv */
package ids_pkg;

	// datapath
	typedef logic [63:0] data_t;
	typedef logic [7:0]  ctrl_t;   // zero on header and payload words

	// flow table
	typedef logic [31:0] ip_t;
	typedef logic [3:0]  action_t;
	typedef logic [3:0]  ft_addr_t;
	typedef logic [31:0] count_t;

	// wishbone side
	typedef logic [2:0]  reg_addr_t;
	typedef logic [31:0] reg_data_t;

	typedef enum logic [1:0] {
		PARSE_START,
		PARSE_HEADER,
		PARSE_PAYLOAD
	} parse_state_t;

	localparam int FT_DEPTH           = 16;
	localparam int IP_WORD_INDEX      = 4;   // header word holding the source ip
	localparam int PAYLOAD_WORD_INDEX = 5;
	localparam int IP_LSB             = 16;

	localparam int FIFO_DEPTH_BITS_DEFAULT = 2;

	// register map, word addresses
	localparam reg_addr_t REG_FT_IP       = 3'd0;
	localparam reg_addr_t REG_FT_ACTION   = 3'd1;
	localparam reg_addr_t REG_FT_CTRL     = 3'd2;
	localparam reg_addr_t REG_CNT_ADDR    = 3'd3;
	localparam reg_addr_t REG_CNT_DATA    = 3'd4;
	localparam reg_addr_t REG_NUM_PKTS    = 3'd5;
	localparam reg_addr_t REG_NUM_MATCHES = 3'd6;
	localparam reg_addr_t REG_LAST_ACTION = 3'd7;

	// REG_FT_CTRL fields, entry index sits in bits 3:0
	localparam int FT_CTRL_WRITE_BIT = 4;
	localparam int FT_CTRL_VALID_BIT = 5;

endpackage

/* rtl/pkt_fifo.sv */
`timescale 1ns/1ps

module pkt_fifo #(
	parameter int FIFO_DEPTH_BITS = ids_pkg::FIFO_DEPTH_BITS_DEFAULT
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           wr_en,
	input  ids_pkg::data_t din_data,
	input  ids_pkg::ctrl_t din_ctrl,
	input  logic           rd_en,
	output ids_pkg::data_t dout_data,
	output ids_pkg::ctrl_t dout_ctrl,
	output logic           empty,
	output logic           nearly_full
);
	import ids_pkg::*;

	localparam int DEPTH = 1 << FIFO_DEPTH_BITS;

	data_t mem_data [DEPTH];
	ctrl_t mem_ctrl [DEPTH];

	logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
	logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
	logic [FIFO_DEPTH_BITS:0]   count;   // one extra bit to tell full from empty

	logic do_wr;
	logic do_rd;

	assign empty       = (count == '0);
	assign nearly_full = (count >= (FIFO_DEPTH_BITS + 1)'(DEPTH - 1));

	assign do_wr = wr_en && (count != (FIFO_DEPTH_BITS + 1)'(DEPTH));   // drop on overflow
	assign do_rd = rd_en && !empty;

	// head word falls through
	assign dout_data = mem_data[rd_ptr];
	assign dout_ctrl = mem_ctrl[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem_data[wr_ptr] <= din_data;
			mem_ctrl[wr_ptr] <= din_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

endmodule

/* rtl/header_parser.sv */
`timescale 1ns/1ps

module header_parser (
	input  logic            clk,
	input  logic            reset,
	input  ids_pkg::data_t  fifo_data,
	input  ids_pkg::ctrl_t  fifo_ctrl,
	input  logic            fifo_empty,
	input  logic            out_rdy,
	output logic            fifo_rd_en,
	output ids_pkg::data_t  out_data,
	output ids_pkg::ctrl_t  out_ctrl,
	output logic            out_wr,
	output logic            lookup_start,
	output ids_pkg::ip_t    lookup_ip,
	output ids_pkg::count_t num_pkts
);
	import ids_pkg::*;

	parse_state_t state;
	parse_state_t state_next;
	logic [2:0]   hdr_count;        // zero-control words seen in this packet
	logic [2:0]   hdr_count_next;
	logic         ip_word;          // popping the word with the source ip
	logic         pkt_done;
	logic         ctrl_word;

	// pop as long as the sink can take the word next cycle
	assign fifo_rd_en = !fifo_empty && out_rdy;
	assign ctrl_word  = (fifo_ctrl != '0);

	always_comb begin
		state_next     = state;
		hdr_count_next = hdr_count;
		ip_word        = 1'b0;
		pkt_done       = 1'b0;

		if (fifo_rd_en) begin
			case (state)
				PARSE_START: begin
					if (ctrl_word)
						state_next = PARSE_HEADER;   // module header word
				end
				PARSE_HEADER: begin
					if (!ctrl_word) begin
						hdr_count_next = hdr_count + 3'd1;
						if (hdr_count_next == 3'(IP_WORD_INDEX))
							ip_word = 1'b1;
						if (hdr_count_next == 3'(PAYLOAD_WORD_INDEX))
							state_next = PARSE_PAYLOAD;
					end
				end
				PARSE_PAYLOAD: begin
					// last word of the packet
					if (ctrl_word) begin
						state_next     = PARSE_START;
						hdr_count_next = '0;
						pkt_done       = 1'b1;
					end
				end
				default: state_next = PARSE_START;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= PARSE_START;
			hdr_count    <= '0;
			out_wr       <= 1'b0;
			lookup_start <= 1'b0;
			num_pkts     <= '0;
		end else begin
			state        <= state_next;
			hdr_count    <= hdr_count_next;
			out_wr       <= fifo_rd_en;
			lookup_start <= ip_word;   // one cycle after the ip word pops
			if (pkt_done)
				num_pkts <= num_pkts + 32'd1;
		end
	end

	// output stage and captured address
	always_ff @(posedge clk) begin
		if (fifo_rd_en) begin
			out_data <= fifo_data;
			out_ctrl <= fifo_ctrl;
		end
		if (ip_word)
			lookup_ip <= fifo_data[IP_LSB +: $bits(ip_t)];
	end

endmodule

/* rtl/flow_table.sv */
`timescale 1ns/1ps

module flow_table (
	input  logic              clk,
	input  logic              reset,
	input  logic              lookup_start,
	input  ids_pkg::ip_t      lookup_ip,
	input  logic              ft_wr_en,
	input  ids_pkg::ft_addr_t ft_wr_addr,
	input  ids_pkg::ip_t      ft_wr_ip,
	input  ids_pkg::action_t  ft_wr_action,
	input  logic              ft_wr_valid,
	input  ids_pkg::ft_addr_t cnt_addr,
	output ids_pkg::count_t   cnt_data,
	output ids_pkg::count_t   num_matches,
	output ids_pkg::action_t  last_action
);
	import ids_pkg::*;

	logic [FT_DEPTH-1:0] entry_valid;
	ip_t                 entry_ip     [FT_DEPTH];
	action_t             entry_action [FT_DEPTH];
	count_t              hit_cnt      [FT_DEPTH];

	logic     hit;
	ft_addr_t hit_idx;

	// compare all entries at once, lowest valid index wins
	always_comb begin
		hit     = 1'b0;
		hit_idx = '0;
		for (int i = FT_DEPTH - 1; i >= 0; i--) begin
			if (entry_valid[i] && (entry_ip[i] == lookup_ip)) begin
				hit     = 1'b1;
				hit_idx = ft_addr_t'(i);
			end
		end
	end

	assign cnt_data = hit_cnt[cnt_addr];

	// table programming from the register block
	always_ff @(posedge clk) begin
		if (reset) begin
			entry_valid <= '0;
			for (int i = 0; i < FT_DEPTH; i++) begin
				entry_ip[i]     <= '0;
				entry_action[i] <= '0;
			end
		end else if (ft_wr_en) begin
			entry_valid[ft_wr_addr]  <= ft_wr_valid;
			entry_ip[ft_wr_addr]     <= ft_wr_ip;
			entry_action[ft_wr_addr] <= ft_wr_action;
		end
	end

	// statistics
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < FT_DEPTH; i++)
				hit_cnt[i] <= '0;
			num_matches <= '0;
			last_action <= '0;
		end else if (lookup_start) begin
			if (hit) begin
				hit_cnt[hit_idx] <= hit_cnt[hit_idx] + 32'd1;
				num_matches      <= num_matches + 32'd1;
				last_action      <= entry_action[hit_idx];
			end else begin
				last_action <= '0;   // miss
			end
		end
	end

endmodule

/* rtl/ids_regs.sv */
`timescale 1ns/1ps

module ids_regs (
	input  logic               clk,
	input  logic               reset,

	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  ids_pkg::reg_addr_t wb_adr,
	input  ids_pkg::reg_data_t wb_wdata,
	output ids_pkg::reg_data_t wb_rdata,
	output logic               wb_ack,

	input  ids_pkg::count_t    num_pkts,
	input  ids_pkg::count_t    cnt_data,
	input  ids_pkg::count_t    num_matches,
	input  ids_pkg::action_t   last_action,

	output logic               ft_wr_en,
	output ids_pkg::ft_addr_t  ft_wr_addr,
	output ids_pkg::ip_t       ft_wr_ip,
	output ids_pkg::action_t   ft_wr_action,
	output logic               ft_wr_valid,
	output ids_pkg::ft_addr_t  cnt_addr
);
	import ids_pkg::*;

	logic      wb_req;     // new request, not yet acked
	logic      wr_req;
	reg_data_t rd_mux;

	assign wb_req = wb_cyc && wb_stb && !wb_ack;
	assign wr_req = wb_req && wb_we;

	always_comb begin
		case (wb_adr)
			REG_FT_IP:       rd_mux = reg_data_t'(ft_wr_ip);
			REG_FT_ACTION:   rd_mux = reg_data_t'(ft_wr_action);
			REG_FT_CTRL:     rd_mux = '0;   // strobe only
			REG_CNT_ADDR:    rd_mux = reg_data_t'(cnt_addr);
			REG_CNT_DATA:    rd_mux = reg_data_t'(cnt_data);
			REG_NUM_PKTS:    rd_mux = reg_data_t'(num_pkts);
			REG_NUM_MATCHES: rd_mux = reg_data_t'(num_matches);
			REG_LAST_ACTION: rd_mux = reg_data_t'(last_action);
			default:         rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack       <= 1'b0;
			ft_wr_en     <= 1'b0;
			ft_wr_ip     <= '0;
			ft_wr_action <= '0;
			cnt_addr     <= '0;
		end else begin
			wb_ack   <= wb_req;   // single cycle ack
			ft_wr_en <= wr_req && (wb_adr == REG_FT_CTRL) && wb_wdata[FT_CTRL_WRITE_BIT];
			if (wr_req) begin
				case (wb_adr)
					REG_FT_IP:     ft_wr_ip     <= wb_wdata[$bits(ip_t)-1:0];
					REG_FT_ACTION: ft_wr_action <= wb_wdata[$bits(action_t)-1:0];
					REG_CNT_ADDR:  cnt_addr     <= wb_wdata[$bits(ft_addr_t)-1:0];
					default: ;
				endcase
			end
		end
	end

	// entry index and valid flag go out with the write strobe
	always_ff @(posedge clk) begin
		if (wr_req && (wb_adr == REG_FT_CTRL)) begin
			ft_wr_addr  <= wb_wdata[$bits(ft_addr_t)-1:0];
			ft_wr_valid <= wb_wdata[FT_CTRL_VALID_BIT];
		end
		if (wb_req)
			wb_rdata <= rd_mux;
	end

endmodule

/* rtl/ids_top.sv */
`timescale 1ns/1ps

module ids_top #(
	parameter int FIFO_DEPTH_BITS = ids_pkg::FIFO_DEPTH_BITS_DEFAULT
) (
	input  logic                clk,
	input  logic                reset,

	input  ids_pkg::data_t      in_data,
	input  ids_pkg::ctrl_t      in_ctrl,
	input  logic                in_wr,
	output logic                in_rdy,

	output ids_pkg::data_t      out_data,
	output ids_pkg::ctrl_t      out_ctrl,
	output logic                out_wr,
	input  logic                out_rdy,

	input  logic                wb_cyc,
	input  logic                wb_stb,
	input  logic                wb_we,
	input  ids_pkg::reg_addr_t  wb_adr,
	input  ids_pkg::reg_data_t  wb_wdata,
	output ids_pkg::reg_data_t  wb_rdata,
	output logic                wb_ack
);
	import ids_pkg::*;

	data_t    fifo_data;
	ctrl_t    fifo_ctrl;
	logic     fifo_empty;
	logic     fifo_rd_en;
	logic     fifo_nearly_full;

	logic     lookup_start;
	ip_t      lookup_ip;
	count_t   num_pkts;

	logic     ft_wr_en;
	ft_addr_t ft_wr_addr;
	ip_t      ft_wr_ip;
	action_t  ft_wr_action;
	logic     ft_wr_valid;
	ft_addr_t cnt_addr;
	count_t   cnt_data;
	count_t   num_matches;
	action_t  last_action;

	assign in_rdy = !fifo_nearly_full;   // two free slots left at least

	pkt_fifo #(
		.FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
	) u_fifo (
		.clk         (clk),
		.reset       (reset),
		.wr_en       (in_wr),
		.din_data    (in_data),
		.din_ctrl    (in_ctrl),
		.rd_en       (fifo_rd_en),
		.dout_data   (fifo_data),
		.dout_ctrl   (fifo_ctrl),
		.empty       (fifo_empty),
		.nearly_full (fifo_nearly_full)
	);

	header_parser u_parser (
		.clk          (clk),
		.reset        (reset),
		.fifo_data    (fifo_data),
		.fifo_ctrl    (fifo_ctrl),
		.fifo_empty   (fifo_empty),
		.out_rdy      (out_rdy),
		.fifo_rd_en   (fifo_rd_en),
		.out_data     (out_data),
		.out_ctrl     (out_ctrl),
		.out_wr       (out_wr),
		.lookup_start (lookup_start),
		.lookup_ip    (lookup_ip),
		.num_pkts     (num_pkts)
	);

	flow_table u_table (
		.clk          (clk),
		.reset        (reset),
		.lookup_start (lookup_start),
		.lookup_ip    (lookup_ip),
		.ft_wr_en     (ft_wr_en),
		.ft_wr_addr   (ft_wr_addr),
		.ft_wr_ip     (ft_wr_ip),
		.ft_wr_action (ft_wr_action),
		.ft_wr_valid  (ft_wr_valid),
		.cnt_addr     (cnt_addr),
		.cnt_data     (cnt_data),
		.num_matches  (num_matches),
		.last_action  (last_action)
	);

	ids_regs u_regs (
		.clk          (clk),
		.reset        (reset),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_wdata     (wb_wdata),
		.wb_rdata     (wb_rdata),
		.wb_ack       (wb_ack),
		.num_pkts     (num_pkts),
		.cnt_data     (cnt_data),
		.num_matches  (num_matches),
		.last_action  (last_action),
		.ft_wr_en     (ft_wr_en),
		.ft_wr_addr   (ft_wr_addr),
		.ft_wr_ip     (ft_wr_ip),
		.ft_wr_action (ft_wr_action),
		.ft_wr_valid  (ft_wr_valid),
		.cnt_addr     (cnt_addr)
	);

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);
	localparam int HALF_PERIOD  = 50;   // 100 ns clock
	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* test/tb_ids_assert.sv */
`timescale 1ns/1ps

module tb_ids_assert (
	input logic clk,
	input logic reset,
	input logic out_wr,
	input logic out_rdy,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack
);
	int assert_errors = 0;   // read by the testbench top

	// a word only leaves when the sink was ready the cycle before
	property out_wr_after_rdy;
		@(posedge clk) disable iff (reset) out_wr |-> $past(out_rdy);
	endproperty

	property ack_single_cycle;
		@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack;
	endproperty

	property ack_needs_request;
		@(posedge clk) disable iff (reset) $rose(wb_ack) |-> $past(wb_cyc && wb_stb);
	endproperty

	property quiet_in_reset;
		@(posedge clk) $past(reset) |-> (!out_wr && !wb_ack);
	endproperty

	assert property (out_wr_after_rdy) else begin
		$error("out_wr high without out_rdy in the previous cycle");
		assert_errors++;
	end

	assert property (ack_single_cycle) else begin
		$error("wb_ack held high for two cycles");
		assert_errors++;
	end

	assert property (ack_needs_request) else begin
		$error("wb_ack rose without cyc and stb");
		assert_errors++;
	end

	assert property (quiet_in_reset) else begin
		$error("out_wr or wb_ack high during reset");
		assert_errors++;
	end

endmodule

bind ids_top tb_ids_assert u_assert (
	.clk     (clk),
	.reset   (reset),
	.out_wr  (out_wr),
	.out_rdy (out_rdy),
	.wb_cyc  (wb_cyc),
	.wb_stb  (wb_stb),
	.wb_ack  (wb_ack)
);

/* test/tb_ids.sv */
`timescale 1ns/1ps

module tb_ids;
	import ids_pkg::*;

	localparam int NUM_PACKETS     = 40;   // bound on packets over all tests
	localparam int MAX_PKT_WORDS   = 1 + PAYLOAD_WORD_INDEX + 8 + 1;
	localparam int WATCHDOG_CYCLES = NUM_PACKETS * MAX_PKT_WORDS * 6 + 3000;
	localparam int DRAIN_LIMIT     = 500;
	localparam int ACK_LIMIT       = 20;

	localparam ip_t IP_A    = 32'h0a00_0001;
	localparam ip_t IP_B    = 32'h0a00_0002;
	localparam ip_t IP_C    = 32'hc0a8_0101;
	localparam ip_t IP_D    = 32'hac10_0505;
	localparam ip_t IP_MISS = 32'h0808_0808;

	logic      clk;
	logic      reset;
	data_t     in_data;
	ctrl_t     in_ctrl;
	logic      in_wr;
	logic      in_rdy;
	data_t     out_data;
	ctrl_t     out_ctrl;
	logic      out_wr;
	logic      out_rdy;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	reg_addr_t wb_adr;
	reg_data_t wb_wdata;
	reg_data_t wb_rdata;
	logic      wb_ack;

	data_t exp_data [$];   // words still owed by the DUT
	ctrl_t exp_ctrl [$];
	int    errors = 0;
	logic  bp_on;

	// flow table model
	logic    model_valid  [FT_DEPTH];
	ip_t     model_ip     [FT_DEPTH];
	action_t model_action [FT_DEPTH];
	count_t  model_cnt    [FT_DEPTH];
	count_t  model_matches;
	action_t model_last;
	count_t  model_pkts;

	tb_clock u_clock (
		.clk   (clk),
		.reset (reset)
	);

	ids_top i_dut (
		.clk      (clk),
		.reset    (reset),
		.in_data  (in_data),
		.in_ctrl  (in_ctrl),
		.in_wr    (in_wr),
		.in_rdy   (in_rdy),
		.out_data (out_data),
		.out_ctrl (out_ctrl),
		.out_wr   (out_wr),
		.out_rdy  (out_rdy),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack)
	);

	task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
		if (actual !== expected) begin
			$display("error: time %0t signal %s got %0h expected %0h", $time, name, actual,
				expected);
			errors++;
		end
	endtask

	// checks every word the DUT writes out
	always @(negedge clk) begin
		if (!reset && out_wr) begin
			if (exp_data.size() == 0) begin
				$display("error: time %0t word %0h left the DUT with none expected", $time,
					out_data);
				errors++;
			end else begin
				check_value("out_data", out_data, exp_data.pop_front());
				check_value("out_ctrl", out_ctrl, exp_ctrl.pop_front());
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles and the tests did not finish",
			WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	task automatic wb_write(reg_addr_t adr, reg_data_t data);
		int waited;
		waited   = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_wdata = data;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && waited < ACK_LIMIT);
		if (!wb_ack) begin
			$display("error: time %0t no ack for a write to register %0d", $time, adr);
			errors++;
		end
		@(negedge clk);   // request still up over the ack edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk);   // idle cycle between accesses
	endtask

	task automatic wb_read(reg_addr_t adr, output reg_data_t data);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && waited < ACK_LIMIT);
		if (!wb_ack) begin
			$display("error: time %0t no ack for a read of register %0d", $time, adr);
			errors++;
		end
		data = wb_rdata;
		@(negedge clk);   // request still up over the ack edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(negedge clk);
	endtask

	task automatic read_expect(reg_addr_t adr, reg_data_t expected, string name);
		reg_data_t value;
		wb_read(adr, value);
		check_value(name, value, expected);
	endtask

	// lowest valid entry holding this address or -1 on a miss
	function automatic int find_entry(ip_t ip);
		for (int i = 0; i < FT_DEPTH; i++) begin
			if (model_valid[i] && model_ip[i] == ip)
				return i;
		end
		return -1;
	endfunction

	task automatic program_entry(ft_addr_t idx, ip_t ip, action_t act, logic valid);
		reg_data_t ctrl_word;
		ctrl_word = reg_data_t'(idx) | (32'd1 << FT_CTRL_WRITE_BIT) |
			(reg_data_t'(valid) << FT_CTRL_VALID_BIT);
		wb_write(REG_FT_IP, ip);
		wb_write(REG_FT_ACTION, reg_data_t'(act));
		wb_write(REG_FT_CTRL, ctrl_word);
		model_valid[idx]  = valid;
		model_ip[idx]     = ip;
		model_action[idx] = act;
	endtask

	task automatic send_word(data_t d, ctrl_t c);
		while (!in_rdy)
			@(negedge clk);
		in_data = d;
		in_ctrl = c;
		in_wr   = 1'b1;
		exp_data.push_back(d);
		exp_ctrl.push_back(c);
		@(negedge clk);
		in_wr = 1'b0;
	endtask

	task automatic send_packet(ip_t ip, int n_payload);
		data_t w;
		ctrl_t last_ctrl;
		int    idx;
		send_word({$urandom, $urandom}, 8'hff);   // module header
		for (int i = 1; i <= PAYLOAD_WORD_INDEX + n_payload; i++) begin
			w = {$urandom, $urandom};
			if (i == IP_WORD_INDEX)
				w[IP_LSB +: 32] = ip;
			send_word(w, 8'h00);
		end
		last_ctrl = ctrl_t'(($urandom % 255) + 1);
		send_word({$urandom, $urandom}, last_ctrl);
		model_pkts++;
		idx = find_entry(ip);
		if (idx >= 0) begin
			model_cnt[idx]++;
			model_matches++;
			model_last = model_action[idx];
		end else begin
			model_last = '0;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_data.size() != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_data.size() != 0) begin
			$display("error: time %0t %0d words never left the DUT", $time, exp_data.size());
			errors++;
			exp_data.delete();
			exp_ctrl.delete();
		end
		repeat (3) @(negedge clk);   // lets the lookup result settle
	endtask

	task automatic check_counters();
		for (int i = 0; i < FT_DEPTH; i++) begin
			wb_write(REG_CNT_ADDR, reg_data_t'(i));
			read_expect(REG_CNT_DATA, model_cnt[i], $sformatf("cnt_data[%0d]", i));
		end
		read_expect(REG_NUM_MATCHES, model_matches, "num_matches");
	endtask

	task automatic send_and_check_action(ip_t ip, int n_payload);
		send_packet(ip, n_payload);
		wait_drain();
		read_expect(REG_LAST_ACTION, reg_data_t'(model_last), "last_action");
	endtask

	task automatic reset_defaults();
		check_value("in_rdy", in_rdy, 1'b1);
		check_value("out_wr", out_wr, 1'b0);
		read_expect(REG_NUM_PKTS, '0, "num_pkts");
		read_expect(REG_NUM_MATCHES, '0, "num_matches");
		read_expect(REG_LAST_ACTION, '0, "last_action");
		read_expect(REG_CNT_DATA, '0, "cnt_data");
		wb_write(REG_FT_IP, 32'hc0a8_0a01);
		read_expect(REG_FT_IP, 32'hc0a8_0a01, "ft_ip");
		wb_write(REG_FT_ACTION, 32'h0000_01a5);
		read_expect(REG_FT_ACTION, 32'h0000_0005, "ft_action");   // 4 bits kept
	endtask

	task automatic pass_through();
		for (int p = 0; p < 8; p++)
			send_packet($urandom, $urandom % 9);
		wait_drain();
		read_expect(REG_NUM_PKTS, model_pkts, "num_pkts");
	endtask

	task automatic back_pressure();
		bp_on = 1'b1;
		fork
			while (bp_on) begin
				@(negedge clk);
				out_rdy = (($urandom % 5) < 3);
			end
		join_none
		for (int p = 0; p < 8; p++)
			send_packet($urandom, $urandom % 9);
		wait_drain();
		bp_on = 1'b0;
		repeat (2) @(negedge clk);
		out_rdy = 1'b1;
		read_expect(REG_NUM_PKTS, model_pkts, "num_pkts");
	endtask

	task automatic flow_matching();
		program_entry(4'd0, IP_A, 4'h3, 1'b1);
		program_entry(4'd1, IP_B, 4'h5, 1'b1);
		program_entry(4'd2, IP_C, 4'h7, 1'b0);   // invalid entry
		program_entry(4'd7, IP_D, 4'h9, 1'b1);
		send_and_check_action(IP_A, 0);
		send_and_check_action(IP_B, 3);
		send_and_check_action(IP_C, 1);
		send_and_check_action(IP_MISS, 2);
		send_and_check_action(IP_D, 0);
		send_and_check_action(IP_A, 4);
		send_and_check_action(IP_B, 1);
		check_counters();
		read_expect(REG_NUM_PKTS, model_pkts, "num_pkts");
	endtask

	task automatic overlapping_entries();
		program_entry(4'd9, IP_D, 4'hc, 1'b1);
		program_entry(4'd12, IP_A, 4'he, 1'b1);
		send_and_check_action(IP_D, 1);
		send_and_check_action(IP_A, 0);
		program_entry(4'd0, IP_A, 4'h3, 1'b0);   // now entry 12 should take it
		send_and_check_action(IP_A, 2);
		check_counters();
	endtask

	initial begin
		void'($urandom(32'hb2e4b0ad));
		in_data  = '0;
		in_ctrl  = '0;
		in_wr    = 1'b0;
		out_rdy  = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_wdata = '0;
		bp_on    = 1'b0;
		for (int i = 0; i < FT_DEPTH; i++) begin
			model_valid[i]  = 1'b0;
			model_ip[i]     = '0;
			model_action[i] = '0;
			model_cnt[i]    = '0;
		end
		model_matches = '0;
		model_last    = '0;
		model_pkts    = '0;

		@(negedge clk);
		while (reset)
			@(negedge clk);

		reset_defaults();
		pass_through();
		back_pressure();
		flow_matching();
		overlapping_entries();

		$display("summary: %0d errors, %0d assertion failures", errors,
			i_dut.u_assert.assert_errors);
		if (errors == 0 && i_dut.u_assert.assert_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* compile.f */
rtl/ids_pkg.sv
rtl/pkt_fifo.sv
rtl/header_parser.sv
rtl/flow_table.sv
rtl/ids_regs.sv
rtl/ids_top.sv
test/tb_clock.sv
test/tb_ids_assert.sv
test/tb_ids.sv
